// ==== src/mem_read_pkg.sv ====
package mem_read_pkg;

  // ==============================
  // bus and PU geometry
  // ==============================
  localparam int AXI_DATA_W = 64;  // one memory beat
  localparam int OP_WIDTH   = 16;
  localparam int NUM_PE     = 8;
  localparam int PU_DATA_W  = OP_WIDTH * NUM_PE;  // one PU word
  localparam int PACK_RATIO = PU_DATA_W / AXI_DATA_W;  // beats per PU word
  localparam int NUM_PU     = 2;
  localparam int PU_ID_W    = 1;
  localparam int TX_SIZE_W  = 10;  // request beat count

  // ==============================
  // buffer depths
  // ==============================
  localparam int INBUF_ADDR_W          = 4;
  localparam int STREAM_FIFO_ADDR_W    = 5;
  localparam int STREAM_PU_FIFO_ADDR_W = 4;
  localparam int BUFFER_READ_ADDR_W    = 6;
  localparam int ALMOST_FULL_MARGIN    = 4;  // free slots left at full
  localparam int READ_INFO_ADDR_W      = 2;  // request queue

  typedef enum logic [1:0] {
    DT_STREAM,     // shared stream buffer, packed
    DT_STREAM_PU,  // per-PU stream buffer, packed
    DT_BUFFER      // buffer-read FIFO, bus width
  } d_type_t;

  typedef enum logic {
    RS_IDLE,
    RS_ROUTE
  } route_state_t;

endpackage

// ==== src/sync_fifo.sv ====
module sync_fifo #(
  parameter int DATA_W = 64,
  parameter int ADDR_W = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              push,
  input  logic              pop,
  input  logic [DATA_W-1:0] data_in,
  output logic [DATA_W-1:0] data_out,
  output logic              full,
  output logic              empty,
  output logic [ADDR_W:0]   fifo_count
);

  localparam int DEPTH = 1 << ADDR_W;

  logic [DATA_W-1:0] mem [0:DEPTH-1];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic              do_push;
  logic              do_pop;

  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;  // pop on empty is dropped
  assign full     = fifo_count == (ADDR_W+1)'(DEPTH);
  assign empty    = fifo_count == '0;
  assign data_out = mem[rd_ptr];  // show-ahead head

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      fifo_count <= fifo_count + (ADDR_W+1)'(do_push) - (ADDR_W+1)'(do_pop);
    end
  end

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= data_in;
  end

  // the producer is expected to stop on its own full flag
  a_no_push_when_full: assert property (@(posedge clk) disable iff (reset)
    push |-> !full);

endmodule

// ==== src/data_packer.sv ====
module data_packer #(
  parameter int IN_W  = 64,
  parameter int OUT_W = 128
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             s_write_req,
  input  logic [IN_W-1:0]  s_write_data,
  output logic             m_write_req,
  output logic [OUT_W-1:0] m_write_data
);

  localparam int RATIO = OUT_W / IN_W;
  localparam int CNT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

  logic [CNT_W-1:0] beat_cnt;
  logic             last_beat;

  assign last_beat = beat_cnt == CNT_W'(RATIO - 1);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      beat_cnt    <= '0;
      m_write_req <= 1'b0;
    end
    else
    begin
      m_write_req <= s_write_req && last_beat;  // word complete next cycle
      if (s_write_req)
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
    end
  end

  // new beat enters at the top, so the first beat ends up in the low part
  always_ff @(posedge clk)
  begin
    if (s_write_req)
    begin
      if (RATIO > 1)
        m_write_data <= {s_write_data, m_write_data[OUT_W-1:IN_W]};
      else
        m_write_data <= OUT_W'(s_write_data);
    end
  end

endmodule

// ==== src/read_info.sv ====
module read_info (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               rd_req,
  input  logic [mem_read_pkg::TX_SIZE_W-1:0] rd_req_size,
  input  logic [mem_read_pkg::PU_ID_W-1:0]   rd_req_pu_id,
  input  mem_read_pkg::d_type_t              rd_req_d_type,
  output logic                               read_info_full,
  input  logic                               inbuf_empty,
  output logic                               inbuf_pop,
  input  logic                               stream_full,
  input  logic                               stream_pu_full,
  input  logic                               buffer_full,
  output logic                               stream_push,
  output logic                               stream_pu_push,
  output logic [mem_read_pkg::PU_ID_W-1:0]   stream_pu_id,
  output logic                               buffer_push
);
  import mem_read_pkg::*;

  localparam int REQ_W = $bits(d_type_t) + PU_ID_W + TX_SIZE_W;

  logic                 req_push;
  logic                 req_pop;
  logic                 req_empty;
  logic [REQ_W-1:0]     req_in;
  logic [REQ_W-1:0]     req_out;
  logic [TX_SIZE_W-1:0] head_size;
  logic [PU_ID_W-1:0]   head_pu_id;
  d_type_t              head_d_type;
  route_state_t         state;
  logic [TX_SIZE_W-1:0] beats_left;
  logic [PU_ID_W-1:0]   cur_pu_id;
  d_type_t              cur_d_type;
  logic                 target_full;

  // ==============================
  // request queue
  // ==============================
  assign req_push = rd_req && !read_info_full;
  assign req_in   = {rd_req_d_type, rd_req_pu_id, rd_req_size};
  assign req_pop  = (state == RS_IDLE) && !req_empty;

  assign head_size   = req_out[TX_SIZE_W-1:0];
  assign head_pu_id  = req_out[TX_SIZE_W +: PU_ID_W];
  assign head_d_type = d_type_t'(req_out[REQ_W-1 -: $bits(d_type_t)]);

  sync_fifo #(
    .DATA_W     (REQ_W),
    .ADDR_W     (READ_INFO_ADDR_W)
  ) req_queue_i (
    .clk        (clk),
    .reset      (reset),
    .push       (req_push),
    .pop        (req_pop),
    .data_in    (req_in),
    .data_out   (req_out),
    .full       (read_info_full),
    .empty      (req_empty),
    .fifo_count ()
  );

  // ==============================
  // beat routing
  // ==============================
  always_comb
  begin
    case (cur_d_type)
      DT_STREAM:    target_full = stream_full;
      DT_STREAM_PU: target_full = stream_pu_full;
      default:      target_full = buffer_full;
    endcase
  end

  assign inbuf_pop = (state == RS_ROUTE) && !inbuf_empty && !target_full;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= RS_IDLE;
      beats_left <= '0;
      cur_pu_id  <= '0;
      cur_d_type <= DT_STREAM;
    end
    else
    begin
      case (state)
        RS_IDLE:
          if (req_pop && head_size != '0)  // zero-size request just retires
          begin
            state      <= RS_ROUTE;
            beats_left <= head_size;
            cur_pu_id  <= head_pu_id;
            cur_d_type <= head_d_type;
          end
        RS_ROUTE:
          if (inbuf_pop)
          begin
            beats_left <= beats_left - 1'b1;
            if (beats_left == TX_SIZE_W'(1))
              state <= RS_IDLE;  // last beat of this request
          end
        default: state <= RS_IDLE;
      endcase
    end
  end

  // pushes trail the pop by one cycle, in step with the top's beat register
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      stream_push    <= 1'b0;
      stream_pu_push <= 1'b0;
      buffer_push    <= 1'b0;
    end
    else
    begin
      stream_push    <= inbuf_pop && cur_d_type == DT_STREAM;
      stream_pu_push <= inbuf_pop && cur_d_type == DT_STREAM_PU;
      buffer_push    <= inbuf_pop && cur_d_type == DT_BUFFER;
    end
  end

  always_ff @(posedge clk)
  begin
    stream_pu_id <= cur_pu_id;
  end

  // packed targets need whole PU words
  a_packed_size: assert property (@(posedge clk) disable iff (reset)
    (req_push && rd_req_d_type != DT_BUFFER) |->
      (rd_req_size % TX_SIZE_W'(PACK_RATIO) == '0));

endmodule

// ==== src/read_buffers.sv ====
module read_buffers (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic [mem_read_pkg::AXI_DATA_W-1:0]       beat_data,
  input  logic                                      stream_push,
  input  logic                                      stream_pu_push,
  input  logic [mem_read_pkg::PU_ID_W-1:0]          stream_pu_id,
  input  logic                                      buffer_push,
  output logic                                      stream_full,
  output logic                                      stream_pu_full,
  output logic                                      buffer_full,
  input  logic                                      stream_fifo_pop,
  output logic                                      stream_fifo_empty,
  output logic [mem_read_pkg::PU_DATA_W-1:0]        stream_fifo_data_out,
  input  logic [mem_read_pkg::NUM_PU-1:0]           stream_pu_pop,
  output logic [mem_read_pkg::NUM_PU-1:0]           stream_pu_empty,
  output logic [mem_read_pkg::NUM_PU*mem_read_pkg::PU_DATA_W-1:0] stream_pu_data_out,
  input  logic                                      buffer_read_pop,
  output logic                                      buffer_read_empty,
  output logic [mem_read_pkg::AXI_DATA_W-1:0]       buffer_read_data_out
);
  import mem_read_pkg::*;

  logic                          stream_word_push;
  logic [PU_DATA_W-1:0]          stream_word;
  logic [STREAM_FIFO_ADDR_W:0]   stream_count;
  logic [BUFFER_READ_ADDR_W:0]   buffer_count;
  logic [NUM_PU-1:0]             lane_almost_full;

  // ==============================
  // shared stream buffer
  // ==============================
  data_packer #(
    .IN_W         (AXI_DATA_W),
    .OUT_W        (PU_DATA_W)
  ) stream_packer_i (
    .clk          (clk),
    .reset        (reset),
    .s_write_req  (stream_push),
    .s_write_data (beat_data),
    .m_write_req  (stream_word_push),
    .m_write_data (stream_word)
  );

  sync_fifo #(
    .DATA_W     (PU_DATA_W),
    .ADDR_W     (STREAM_FIFO_ADDR_W)
  ) stream_fifo_i (
    .clk        (clk),
    .reset      (reset),
    .push       (stream_word_push),
    .pop        (stream_fifo_pop),
    .data_in    (stream_word),
    .data_out   (stream_fifo_data_out),
    .full       (),
    .empty      (stream_fifo_empty),
    .fifo_count (stream_count)
  );

  // ==============================
  // per-PU stream buffers
  // ==============================
  genvar i;
  generate
    for (i = 0; i < NUM_PU; i++)
    begin : g_stream_pu
      logic                           lane_push;
      logic                           lane_word_push;
      logic [PU_DATA_W-1:0]           lane_word;
      logic [STREAM_PU_FIFO_ADDR_W:0] lane_count;

      assign lane_push = stream_pu_push && (stream_pu_id == PU_ID_W'(i));  // selected lane only

      data_packer #(
        .IN_W         (AXI_DATA_W),
        .OUT_W        (PU_DATA_W)
      ) lane_packer_i (
        .clk          (clk),
        .reset        (reset),
        .s_write_req  (lane_push),
        .s_write_data (beat_data),
        .m_write_req  (lane_word_push),
        .m_write_data (lane_word)
      );

      sync_fifo #(
        .DATA_W     (PU_DATA_W),
        .ADDR_W     (STREAM_PU_FIFO_ADDR_W)
      ) lane_fifo_i (
        .clk        (clk),
        .reset      (reset),
        .push       (lane_word_push),
        .pop        (stream_pu_pop[i]),
        .data_in    (lane_word),
        .data_out   (stream_pu_data_out[i*PU_DATA_W +: PU_DATA_W]),
        .full       (),
        .empty      (stream_pu_empty[i]),
        .fifo_count (lane_count)
      );

      assign lane_almost_full[i] = lane_count >=
        (STREAM_PU_FIFO_ADDR_W+1)'((1 << STREAM_PU_FIFO_ADDR_W) - ALMOST_FULL_MARGIN);
    end
  endgenerate

  // ==============================
  // buffer-read FIFO
  // ==============================
  sync_fifo #(
    .DATA_W     (AXI_DATA_W),
    .ADDR_W     (BUFFER_READ_ADDR_W)
  ) buffer_read_fifo_i (
    .clk        (clk),
    .reset      (reset),
    .push       (buffer_push),
    .pop        (buffer_read_pop),
    .data_in    (beat_data),
    .data_out   (buffer_read_data_out),
    .full       (),
    .empty      (buffer_read_empty),
    .fifo_count (buffer_count)
  );

  // margin absorbs the beats already popped from the input buffer
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      stream_full    <= 1'b0;
      stream_pu_full <= 1'b0;
      buffer_full    <= 1'b0;
    end
    else
    begin
      stream_full    <= stream_count >=
        (STREAM_FIFO_ADDR_W+1)'((1 << STREAM_FIFO_ADDR_W) - ALMOST_FULL_MARGIN);
      stream_pu_full <= |lane_almost_full;  // any lane holds off PU traffic
      buffer_full    <= buffer_count >=
        (BUFFER_READ_ADDR_W+1)'((1 << BUFFER_READ_ADDR_W) - ALMOST_FULL_MARGIN);
    end
  end

endmodule

// ==== src/mem_read_router_top.sv ====
module mem_read_router_top (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      rd_req,
  input  logic [mem_read_pkg::TX_SIZE_W-1:0]        rd_req_size,
  input  logic [mem_read_pkg::PU_ID_W-1:0]          rd_req_pu_id,
  input  mem_read_pkg::d_type_t                     rd_req_d_type,
  output logic                                      rd_ready,
  input  logic                                      rd_data_valid,
  input  logic [mem_read_pkg::AXI_DATA_W-1:0]       rd_data,
  output logic                                      rd_data_ready,
  input  logic                                      stream_fifo_pop,
  output logic                                      stream_fifo_empty,
  output logic [mem_read_pkg::PU_DATA_W-1:0]        stream_fifo_data_out,
  input  logic [mem_read_pkg::NUM_PU-1:0]           stream_pu_pop,
  output logic [mem_read_pkg::NUM_PU-1:0]           stream_pu_empty,
  output logic [mem_read_pkg::NUM_PU*mem_read_pkg::PU_DATA_W-1:0] stream_pu_data_out,
  input  logic                                      buffer_read_pop,
  output logic                                      buffer_read_empty,
  output logic [mem_read_pkg::AXI_DATA_W-1:0]       buffer_read_data_out
);
  import mem_read_pkg::*;

  logic                  inbuf_push;
  logic                  inbuf_pop;
  logic                  inbuf_full;
  logic                  inbuf_empty;
  logic [AXI_DATA_W-1:0] inbuf_data_out;
  logic [AXI_DATA_W-1:0] beat_data;
  logic                  read_info_full;
  logic                  stream_push;
  logic                  stream_pu_push;
  logic [PU_ID_W-1:0]    stream_pu_id;
  logic                  buffer_push;
  logic                  stream_full;
  logic                  stream_pu_full;
  logic                  buffer_full;

  assign rd_ready      = !read_info_full;
  assign rd_data_ready = !inbuf_full;
  assign inbuf_push    = rd_data_valid && rd_data_ready;

  // ==============================
  // input buffer
  // ==============================
  sync_fifo #(
    .DATA_W     (AXI_DATA_W),
    .ADDR_W     (INBUF_ADDR_W)
  ) inbuf_i (
    .clk        (clk),
    .reset      (reset),
    .push       (inbuf_push),
    .pop        (inbuf_pop),
    .data_in    (rd_data),
    .data_out   (inbuf_data_out),
    .full       (inbuf_full),
    .empty      (inbuf_empty),
    .fifo_count ()
  );

  always_ff @(posedge clk)
  begin
    if (inbuf_pop)
      beat_data <= inbuf_data_out;  // lines up with the routing push
  end

  read_info read_info_i (
    .clk            (clk),
    .reset          (reset),
    .rd_req         (rd_req),
    .rd_req_size    (rd_req_size),
    .rd_req_pu_id   (rd_req_pu_id),
    .rd_req_d_type  (rd_req_d_type),
    .read_info_full (read_info_full),
    .inbuf_empty    (inbuf_empty),
    .inbuf_pop      (inbuf_pop),
    .stream_full    (stream_full),
    .stream_pu_full (stream_pu_full),
    .buffer_full    (buffer_full),
    .stream_push    (stream_push),
    .stream_pu_push (stream_pu_push),
    .stream_pu_id   (stream_pu_id),
    .buffer_push    (buffer_push)
  );

  read_buffers read_buffers_i (
    .clk                  (clk),
    .reset                (reset),
    .beat_data            (beat_data),
    .stream_push          (stream_push),
    .stream_pu_push       (stream_pu_push),
    .stream_pu_id         (stream_pu_id),
    .buffer_push          (buffer_push),
    .stream_full          (stream_full),
    .stream_pu_full       (stream_pu_full),
    .buffer_full          (buffer_full),
    .stream_fifo_pop      (stream_fifo_pop),
    .stream_fifo_empty    (stream_fifo_empty),
    .stream_fifo_data_out (stream_fifo_data_out),
    .stream_pu_pop        (stream_pu_pop),
    .stream_pu_empty      (stream_pu_empty),
    .stream_pu_data_out   (stream_pu_data_out),
    .buffer_read_pop      (buffer_read_pop),
    .buffer_read_empty    (buffer_read_empty),
    .buffer_read_data_out (buffer_read_data_out)
  );

endmodule

// ==== verification/mem_read_tests.svh ====
// ==============================
// stimulus and drain helpers
// ==============================
task automatic send_request(input int size, input int pu_id, input d_type_t d_type);
  while (!rd_ready)
    step();  // request queue full
  rd_req        = 1'b1;
  rd_req_size   = TX_SIZE_W'(size);
  rd_req_pu_id  = PU_ID_W'(pu_id);
  rd_req_d_type = d_type;
  step();
  rd_req = 1'b0;
endtask

// random beats for one request, with the words its destination should show
task automatic make_beats(input int count, input d_type_t d_type);
  logic [AXI_DATA_W-1:0] beat;
  logic [AXI_DATA_W-1:0] low_half;
  int                    i;
  low_half = '0;
  for (i = 0; i < count; i++)
  begin
    beat = {$random(seed), $random(seed)};
    tx_beats.push_back(beat);
    if (d_type == DT_BUFFER)
      buffer_exp.push_back(beat);
    else if (i % 2 == 0)
      low_half = beat;  // first beat of a word
    else if (d_type == DT_STREAM)
      stream_exp.push_back({beat, low_half});
    else
      pu_exp.push_back({beat, low_half});
  end
endtask

task automatic send_all();
  logic taken;
  while (tx_beats.size() != 0)
  begin
    rd_data_valid = 1'b1;
    rd_data       = tx_beats[0];
    taken         = rd_data_ready;  // holds until the next edge
    if (!taken)
      stall_seen = 1'b1;
    step();
    if (taken)
      void'(tx_beats.pop_front());
  end
  rd_data_valid = 1'b0;
endtask

task automatic drain_buffer();
  while (buffer_exp.size() != 0)
  begin
    if (!buffer_read_empty)
    begin
      check_value("buffer_read_data_out", PU_DATA_W'(buffer_exp.pop_front()),
                  PU_DATA_W'(buffer_read_data_out));
      buffer_read_pop = 1'b1;
    end
    else
      buffer_read_pop = 1'b0;
    step();
  end
  buffer_read_pop = 1'b0;
endtask

task automatic drain_stream();
  while (stream_exp.size() != 0)
  begin
    if (!stream_fifo_empty)
    begin
      check_value("stream_fifo_data_out", stream_exp.pop_front(), stream_fifo_data_out);
      stream_fifo_pop = 1'b1;
    end
    else
      stream_fifo_pop = 1'b0;
    step();
  end
  stream_fifo_pop = 1'b0;
endtask

task automatic drain_pu(input int pu);
  int lane;
  while (pu_exp.size() != 0)
  begin
    for (lane = 0; lane < NUM_PU; lane++)
      if (lane != pu)
        check_flag($sformatf("stream_pu_empty[%0d]", lane), 1'b1, stream_pu_empty[lane]);
    stream_pu_pop = '0;
    if (!stream_pu_empty[pu])
    begin
      check_value($sformatf("stream_pu_data_out[%0d]", pu), pu_exp.pop_front(),
                  stream_pu_data_out[pu*PU_DATA_W +: PU_DATA_W]);
      stream_pu_pop[pu] = 1'b1;
    end
    step();
  end
  stream_pu_pop = '0;
endtask

task automatic expect_idle_levels();
  int lane;
  check_flag("rd_ready", 1'b1, rd_ready);
  check_flag("rd_data_ready", 1'b1, rd_data_ready);
  check_flag("stream_fifo_empty", 1'b1, stream_fifo_empty);
  for (lane = 0; lane < NUM_PU; lane++)
    check_flag($sformatf("stream_pu_empty[%0d]", lane), 1'b1, stream_pu_empty[lane]);
  check_flag("buffer_read_empty", 1'b1, buffer_read_empty);
endtask

task automatic settle_then_expect_idle();
  repeat (8) step();  // a stray word would surface by now
  expect_idle_levels();
endtask

// ==============================
// directed tests
// ==============================
task automatic check_after_reset();
  expect_idle_levels();
endtask

task automatic buffer_read_order();
  send_request(8, 0, DT_BUFFER);
  make_beats(8, DT_BUFFER);
  send_all();
  drain_buffer();
  settle_then_expect_idle();
endtask

task automatic stream_packing();
  send_request(8, 0, DT_STREAM);
  make_beats(8, DT_STREAM);
  send_all();
  drain_stream();
  settle_then_expect_idle();
endtask

task automatic pu_lane_select();
  send_request(8, 1, DT_STREAM_PU);
  make_beats(8, DT_STREAM_PU);
  send_all();
  drain_pu(1);  // lane 0 checked empty every cycle
  settle_then_expect_idle();
endtask

// long enough to fill the stream FIFO to its margin and then the input buffer
task automatic back_pressure();
  stall_seen = 1'b0;
  send_request(96, 0, DT_STREAM);
  make_beats(96, DT_STREAM);
  fork
    send_all();
    begin
      while (!stall_seen && tx_beats.size() != 0)
        step();
      drain_stream();
    end
  join
  assert (stall_seen)
  else
    stop_on_error("rd_data_ready never went low while stream beats were still waiting");
  settle_then_expect_idle();
endtask

task automatic mixed_requests();
  send_request(6, 0, DT_BUFFER);
  send_request(4, 0, DT_STREAM_PU);
  send_request(8, 0, DT_STREAM);
  make_beats(6, DT_BUFFER);
  make_beats(4, DT_STREAM_PU);
  make_beats(8, DT_STREAM);
  send_all();
  drain_buffer();
  drain_pu(0);
  drain_stream();
  settle_then_expect_idle();
endtask

// ==== verification/tb_mem_read_router.sv ====
module tb_mem_read_router;
  timeunit 1ns;
  timeprecision 100ps;
  import mem_read_pkg::*;

  // the directed sequence runs in well under 1000 cycles
  localparam int TIMEOUT_CYCLES = 5000;

  logic                          clk;
  logic                          reset;
  logic                          rd_req;
  logic [TX_SIZE_W-1:0]          rd_req_size;
  logic [PU_ID_W-1:0]            rd_req_pu_id;
  d_type_t                       rd_req_d_type;
  logic                          rd_ready;
  logic                          rd_data_valid;
  logic [AXI_DATA_W-1:0]         rd_data;
  logic                          rd_data_ready;
  logic                          stream_fifo_pop;
  logic                          stream_fifo_empty;
  logic [PU_DATA_W-1:0]          stream_fifo_data_out;
  logic [NUM_PU-1:0]             stream_pu_pop;
  logic [NUM_PU-1:0]             stream_pu_empty;
  logic [NUM_PU*PU_DATA_W-1:0]   stream_pu_data_out;
  logic                          buffer_read_pop;
  logic                          buffer_read_empty;
  logic [AXI_DATA_W-1:0]         buffer_read_data_out;

  int                    seed;
  int                    cycle_count;
  bit                    stall_seen;  // rd_data_ready seen low with a beat waiting
  logic [AXI_DATA_W-1:0] tx_beats [$];  // beats still to be sent
  logic [AXI_DATA_W-1:0] buffer_exp [$];
  logic [PU_DATA_W-1:0]  stream_exp [$];
  logic [PU_DATA_W-1:0]  pu_exp [$];

  mem_read_router_top mem_read_router_top_i (
    .clk                  (clk),
    .reset                (reset),
    .rd_req               (rd_req),
    .rd_req_size          (rd_req_size),
    .rd_req_pu_id         (rd_req_pu_id),
    .rd_req_d_type        (rd_req_d_type),
    .rd_ready             (rd_ready),
    .rd_data_valid        (rd_data_valid),
    .rd_data              (rd_data),
    .rd_data_ready        (rd_data_ready),
    .stream_fifo_pop      (stream_fifo_pop),
    .stream_fifo_empty    (stream_fifo_empty),
    .stream_fifo_data_out (stream_fifo_data_out),
    .stream_pu_pop        (stream_pu_pop),
    .stream_pu_empty      (stream_pu_empty),
    .stream_pu_data_out   (stream_pu_data_out),
    .buffer_read_pop      (buffer_read_pop),
    .buffer_read_empty    (buffer_read_empty),
    .buffer_read_data_out (buffer_read_data_out)
  );

  // ==============================
  // checking helpers
  // ==============================
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [PU_DATA_W-1:0] expected,
                             input logic [PU_DATA_W-1:0] actual);
    assert (actual === expected)
    else
      stop_on_error($sformatf("[FAIL] time %0d ns: %s expected %h, got %h",
                              $time, name, expected, actual));
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    assert (actual === expected)
    else
      stop_on_error($sformatf("[FAIL] time %0d ns: %s expected %b, got %b",
                              $time, name, expected, actual));
  endtask

  task automatic step();
    @(posedge clk);
    #1;  // inputs change and outputs are read here
  endtask

  `include "mem_read_tests.svh"

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial
  begin
    cycle_count = 0;
    forever
    begin
      @(posedge clk);
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES)
        stop_on_error("timeout: the test sequence did not finish in time");
    end
  end

  initial
  begin
    seed            = 27;
    stall_seen      = 1'b0;
    reset           = 1'b1;
    rd_req          = 1'b0;
    rd_req_size     = '0;
    rd_req_pu_id    = '0;
    rd_req_d_type   = DT_STREAM;
    rd_data_valid   = 1'b0;
    rd_data         = '0;
    stream_fifo_pop = 1'b0;
    stream_pu_pop   = '0;
    buffer_read_pop = 1'b0;
    repeat (4) @(posedge clk);
    #1 reset = 1'b0;

    check_after_reset();
    buffer_read_order();
    stream_packing();
    pu_lane_select();
    back_pressure();
    mixed_requests();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== mem_read_router.f ====
+incdir+verification
src/mem_read_pkg.sv
src/sync_fifo.sv
src/data_packer.sv
src/read_info.sv
src/read_buffers.sv
src/mem_read_router_top.sv
verification/tb_mem_read_router.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
  --timescale 1ns/100ps \
  --top-module tb_mem_read_router \
  -f mem_read_router.f \
  -o sim_mem_read_router
./obj_dir/sim_mem_read_router
